// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ----------------------------------------------------------------------------
// Core widths
// ----------------------------------------------------------------------------

// Data and address width.
`define CORE_XLEN 32

// Register file index width.
`define CORE_REG_BITS 5

// ----------------------------------------------------------------------------
// Reset values
// ----------------------------------------------------------------------------

// PC that the front end starts from and the idle redirect target.
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== rtl/isa_pkg.sv ====
`include "core_macros.svh"

package isa_pkg;

    // ------------------------------------------------------------------------
    // RV32I major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    localparam int unsigned shamt_bits = $clog2(`CORE_XLEN); // Shift amount width.

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_e; // Same codes as the branch funct3 field.

    typedef enum logic [1:0] {
        res_alu      = 2'd0,
        res_mem      = 2'd1,
        res_pc_plus4 = 2'd2
    } result_src_e;

endpackage

// ==== rtl/pipe_pkg.sv ====
`include "core_macros.svh"

package pipe_pkg;

    import isa_pkg::*;

    // ------------------------------------------------------------------------
    // Decode to execute
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                      reg_write;
        logic                      mem_write;
        result_src_e               result_src;
        alu_op_e                   alu_op;
        logic                      alu_src_a;       // Operand A is the PC.
        logic                      alu_src_b;       // Operand B is the immediate.
        logic                      branch;
        logic                      jump;
        logic                      pc_target_src;   // Target base is r_out1 (jalr).
        branch_e                   branch_type;
        logic [`CORE_XLEN-1:0]     pc;
        logic [`CORE_XLEN-1:0]     pc_plus4;
        logic [`CORE_XLEN-1:0]     imm;
        logic [`CORE_XLEN-1:0]     r_out1;
        logic [`CORE_XLEN-1:0]     r_out2;
        logic [`CORE_REG_BITS-1:0] rd;
        logic [`CORE_REG_BITS-1:0] ra;
        logic [`CORE_REG_BITS-1:0] rb;
        logic [6:0]                opcode;
        logic                      prediction_made;
        logic                      predicted_taken;
        logic [`CORE_XLEN-1:0]     btb_target;
    } de_payload_t;

    // ------------------------------------------------------------------------
    // Execute to write-back
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                      reg_write;
        result_src_e               result_src;
        logic                      mem_write;
        logic [`CORE_REG_BITS-1:0] rd;
        logic [`CORE_XLEN-1:0]     result;
        logic [`CORE_XLEN-1:0]     store_data;
    } ew_payload_t;

endpackage

// ==== rtl/de_bus_if.sv ====
`timescale 1ns/1ns

interface de_bus_if import pipe_pkg::*; ();

    de_payload_t payload;
    logic        en;
    logic        flush;
    logic        no_op;

    modport decoder (
        output payload
    );

    modport core (
        output en, flush, no_op
    );

    modport sink (
        input payload, en, flush, no_op
    );

endinterface

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic [31:0]            instr,
    input  logic [`CORE_XLEN-1:0]  pc,
    input  logic [`CORE_XLEN-1:0]  r_out1,
    input  logic [`CORE_XLEN-1:0]  r_out2,
    input  logic                   prediction_made,
    input  logic                   predicted_taken,
    input  logic [`CORE_XLEN-1:0]  btb_target,
    de_bus_if.decoder              bus
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  alt;    // Bit 5 of funct7 selects sub and sra.
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;
    de_payload_t           dec;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub_sra,
                                                input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && sub_sra) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sub_sra ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // ------------------------------------------------------------------------
    // Immediate formats
    // ------------------------------------------------------------------------
    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], {(`CORE_XLEN-20){1'b0}}};
    assign imm_j = {{(`CORE_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        dec                 = '0; // Unknown opcodes stay a bubble for control.
        dec.pc              = pc;
        dec.pc_plus4        = pc + `CORE_XLEN'd4;
        dec.r_out1          = r_out1;
        dec.r_out2          = r_out2;
        dec.rd              = instr[11:7];
        dec.ra              = instr[19:15];
        dec.rb              = instr[24:20];
        dec.opcode          = opcode;
        dec.prediction_made = prediction_made;
        dec.predicted_taken = predicted_taken;
        dec.btb_target      = btb_target;
        dec.result_src      = res_alu;
        dec.alu_op          = alu_add;
        dec.branch_type     = br_eq;
        case (opcode)
            opc_op: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_from_funct3(funct3, alt, 1'b1);
            end
            opc_op_imm: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_from_funct3(funct3, alt, 1'b0);
                dec.alu_src_b = 1'b1;
                dec.imm       = imm_i;
            end
            opc_lui: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_pass_b;
                dec.alu_src_b = 1'b1;
                dec.imm       = imm_u;
            end
            opc_auipc: begin
                dec.reg_write = 1'b1;
                dec.alu_src_a = 1'b1;
                dec.alu_src_b = 1'b1;
                dec.imm       = imm_u;
            end
            opc_jal: begin
                dec.reg_write  = 1'b1;
                dec.jump       = 1'b1;
                dec.result_src = res_pc_plus4;
                dec.imm        = imm_j;
            end
            opc_jalr: begin
                dec.reg_write     = 1'b1;
                dec.jump          = 1'b1;
                dec.pc_target_src = 1'b1;
                dec.result_src    = res_pc_plus4;
                dec.imm           = imm_i;
            end
            opc_branch: begin
                dec.branch      = 1'b1;
                dec.branch_type = branch_e'(funct3);
                dec.imm         = imm_b;
            end
            opc_load: begin
                dec.reg_write  = 1'b1;
                dec.result_src = res_mem;
                dec.alu_src_b  = 1'b1;
                dec.imm        = imm_i;
            end
            opc_store: begin
                dec.mem_write = 1'b1;
                dec.alu_src_b = 1'b1;
                dec.imm       = imm_s;
            end
            default: begin
                dec.reg_write = 1'b0;
            end
        endcase
    end

    assign bus.payload = dec;

endmodule

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     flush,
    input  logic     no_op,
    input  payload_t d,
    output payload_t q
);

    // ------------------------------------------------------------------------
    // A zero payload is a bubble, so reset and kill share one path.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (flush || no_op) begin
            q <= '0;          // Wins over a low enable.
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  de_payload_t           de,
    output ew_payload_t           ew,
    output logic                  mispredict,
    output logic [`CORE_XLEN-1:0] redirect_pc
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_y;
    logic [`CORE_XLEN-1:0] base_sum;
    logic [`CORE_XLEN-1:0] target;
    logic [shamt_bits-1:0] shamt;
    logic                  cond;
    logic                  taken;
    logic                  pred_taken;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    assign op_a  = de.alu_src_a ? de.pc : de.r_out1;
    assign op_b  = de.alu_src_b ? de.imm : de.r_out2;
    assign shamt = op_b[shamt_bits-1:0];

    always_comb begin
        case (de.alu_op)
            alu_add:    alu_y = op_a + op_b;
            alu_sub:    alu_y = op_a - op_b;
            alu_sll:    alu_y = op_a << shamt;
            alu_slt:    alu_y = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_y = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_y = op_a ^ op_b;
            alu_srl:    alu_y = op_a >> shamt;
            alu_sra:    alu_y = $unsigned($signed(op_a) >>> shamt);
            alu_or:     alu_y = op_a | op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_pass_b: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Branch resolution
    // ------------------------------------------------------------------------
    always_comb begin
        case (de.branch_type)
            br_eq:   cond = (de.r_out1 == de.r_out2);
            br_ne:   cond = (de.r_out1 != de.r_out2);
            br_lt:   cond = ($signed(de.r_out1) < $signed(de.r_out2));
            br_ge:   cond = ($signed(de.r_out1) >= $signed(de.r_out2));
            br_ltu:  cond = (de.r_out1 < de.r_out2);
            br_geu:  cond = (de.r_out1 >= de.r_out2);
            default: cond = 1'b0; // Reserved funct3 never branches.
        endcase
    end

    assign base_sum   = (de.pc_target_src ? de.r_out1 : de.pc) + de.imm;
    assign target     = de.pc_target_src ? {base_sum[`CORE_XLEN-1:1], 1'b0} : base_sum;
    assign taken      = de.jump || (de.branch && cond);
    assign pred_taken = de.prediction_made && de.predicted_taken;

    assign mispredict = (pred_taken != taken) ||
                        (taken && pred_taken && (de.btb_target != target));

    always_comb begin
        if (!mispredict) begin
            redirect_pc = `CORE_RESET_PC;
        end else if (taken) begin
            redirect_pc = target;
        end else begin
            redirect_pc = de.pc_plus4; // Predicted taken but fell through.
        end
    end

    // ------------------------------------------------------------------------
    // Write-back payload
    // ------------------------------------------------------------------------
    assign ew.reg_write  = de.reg_write;
    assign ew.result_src = de.result_src;
    assign ew.mem_write  = de.mem_write;
    assign ew.rd         = de.rd;
    assign ew.result     = de.jump ? de.pc_plus4 : alu_y; // Link address for jal and jalr.
    assign ew.store_data = de.r_out2;

endmodule

// ==== rtl/decode_execute_core.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_execute_core import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      stall,
    input  logic                      no_op,
    input  logic [31:0]               instr,
    input  logic [`CORE_XLEN-1:0]     pc,
    input  logic [`CORE_XLEN-1:0]     r_out1,
    input  logic [`CORE_XLEN-1:0]     r_out2,
    input  logic                      prediction_made,
    input  logic                      predicted_taken,
    input  logic [`CORE_XLEN-1:0]     btb_target,
    output logic                      reg_write,
    output logic                      mem_write,
    output logic [1:0]                result_src,
    output logic [`CORE_REG_BITS-1:0] rd,
    output logic [`CORE_XLEN-1:0]     result,
    output logic [`CORE_XLEN-1:0]     store_data,
    output logic                      redirect_valid,
    output logic [`CORE_XLEN-1:0]     redirect_pc
);

    de_payload_t de_q;
    ew_payload_t ew_d;
    ew_payload_t ew_q;
    logic        mispredict;

    de_bus_if de_if ();

    // ------------------------------------------------------------------------
    // D/E control. A stall keeps the bubble and flush paths off as well.
    // ------------------------------------------------------------------------
    assign de_if.en    = in_valid && !stall;
    assign de_if.flush = mispredict && !stall;
    assign de_if.no_op = !stall && (no_op || !in_valid);

    decode_unit i_decode_unit (
        .instr           (instr),
        .pc              (pc),
        .r_out1          (r_out1),
        .r_out2          (r_out2),
        .prediction_made (prediction_made),
        .predicted_taken (predicted_taken),
        .btb_target      (btb_target),
        .bus             (de_if.decoder)
    );

    pipe_reg #(.payload_t(de_payload_t)) i_de_reg (
        .clk   (clk),
        .rst   (rst),
        .en    (de_if.en),
        .flush (de_if.flush),
        .no_op (de_if.no_op),
        .d     (de_if.payload),
        .q     (de_q)
    );

    execute_unit i_execute_unit (
        .de          (de_q),
        .ew          (ew_d),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    pipe_reg #(.payload_t(ew_payload_t)) i_ew_reg (
        .clk   (clk),
        .rst   (rst),
        .en    (!stall),
        .flush (1'b0),
        .no_op (1'b0),
        .d     (ew_d),
        .q     (ew_q)
    );

    assign redirect_valid = mispredict;
    assign reg_write      = ew_q.reg_write;
    assign mem_write      = ew_q.mem_write;
    assign result_src     = ew_q.result_src;
    assign rd             = ew_q.rd;
    assign result         = ew_q.result;
    assign store_data     = ew_q.store_data;

endmodule

// ==== verification/tb_decode_execute_core.sv ====
`timescale 1ns/1ns

module tb_decode_execute_core;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic [1:0]  result_src;
        logic [4:0]  rd;
        logic        res_chk;      // Result is defined for this instruction.
        logic [31:0] result;
        logic [31:0] store_data;
        logic        redirect;
        logic [31:0] redirect_pc;
    } exp_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic        pm;
        logic        pt;
        logic [31:0] btb;
        logic        valid;
        logic        stall;
        logic        no_op;
        exp_t        exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        stall;
    logic        no_op;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] r_out1;
    logic [31:0] r_out2;
    logic        prediction_made;
    logic        predicted_taken;
    logic [31:0] btb_target;
    logic        reg_write;
    logic        mem_write;
    logic [1:0]  result_src;
    logic [4:0]  rd;
    logic [31:0] result;
    logic [31:0] store_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    row_t   rows[$];
    exp_t   de_model;     // Expected content of D/E.
    exp_t   ew_model;     // Expected content of E/W.
    integer seed = 32'h2220e3bb;
    int     errors;
    int     checks;
    int     step;
    bit     ok;

    decode_execute_core i_decode_execute_core (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .stall           (stall),
        .no_op           (no_op),
        .instr           (instr),
        .pc              (pc),
        .r_out1          (r_out1),
        .r_out2          (r_out2),
        .prediction_made (prediction_made),
        .predicted_taken (predicted_taken),
        .btb_target      (btb_target),
        .reg_write       (reg_write),
        .mem_write       (mem_write),
        .result_src      (result_src),
        .rd              (rd),
        .result          (result),
        .store_data      (store_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Instruction encoders with x1 and x2 as source registers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd_i);
        return {f7, 5'd2, 5'd1, f3, rd_i, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd_i, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd_i, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd_i,
                                           input logic [6:0] opc);
        return {imm, rd_i, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd_i);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd_i, 7'h6f};
    endfunction

    // ------------------------------------------------------------------------
    // Reference model of one instruction per RV32I
    // ------------------------------------------------------------------------
    function automatic exp_t predict(input logic [31:0] ins, input logic [31:0] pc_i,
                                     input logic [31:0] a, input logic [31:0] b,
                                     input logic pm, input logic pt, input logic [31:0] btb);
        exp_t        e;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] opb;
        logic [31:0] tgt;
        logic [4:0]  sh;
        logic [2:0]  f3;
        logic        taken;
        logic        cond;
        e     = '0;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        opb   = (ins[6:0] == 7'h33) ? b : imm_i;
        sh    = opb[4:0];
        tgt   = pc_i + imm_b;
        taken = 1'b0;
        cond  = 1'b0;
        e.rd         = ins[11:7];
        e.store_data = b;
        e.res_chk    = 1'b1;
        case (ins[6:0])
            7'h33, 7'h13: begin
                e.reg_write = 1'b1;
                case (f3)
                    3'd0: e.result = (ins[5] && ins[30]) ? a - opb : a + opb;
                    3'd1: e.result = a << sh;
                    3'd2: e.result = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    3'd3: e.result = (a < opb) ? 32'd1 : 32'd0;
                    3'd4: e.result = a ^ opb;
                    3'd5: begin
                        if (ins[30]) e.result = $signed(a) >>> sh;
                        else e.result = a >> sh;
                    end
                    3'd6: e.result = a | opb;
                    default: e.result = a & opb;
                endcase
            end
            7'h37: begin
                e.reg_write = 1'b1;
                e.result    = imm_u;
            end
            7'h17: begin
                e.reg_write = 1'b1;
                e.result    = pc_i + imm_u;
            end
            7'h03: begin
                e.reg_write  = 1'b1;
                e.result_src = 2'd1;
                e.result     = a + imm_i;   // Load address.
            end
            7'h23: begin
                e.mem_write = 1'b1;
                e.result    = a + imm_s;
            end
            7'h6f, 7'h67: begin
                e.reg_write  = 1'b1;
                e.result_src = 2'd2;
                e.result     = pc_i + 32'd4;
                taken        = 1'b1;
                if (ins[6:0] == 7'h6f) tgt = pc_i + imm_j;
                else tgt = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                e.res_chk = 1'b0;
                case (f3)
                    3'd0: cond = (a == b);
                    3'd1: cond = (a != b);
                    3'd4: cond = ($signed(a) < $signed(b));
                    3'd5: cond = ($signed(a) >= $signed(b));
                    3'd6: cond = (a < b);
                    3'd7: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                taken = cond;
            end
            default: e.res_chk = 1'b0;
        endcase
        e.redirect    = ((pm && pt) != taken) || (taken && (btb != tgt));
        e.redirect_pc = taken ? tgt : pc_i + 32'd4;
        return e;
    endfunction

    function automatic logic [31:0] next_pc();
        return 32'h100 + 32'(rows.size() * 4);
    endfunction

    task automatic add_row(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                           input logic rnd, input logic [1:0] pred, input logic [31:0] btb,
                           input logic valid, input logic stl, input logic nop);
        row_t r;
        r.instr = ins;
        r.pc    = next_pc();
        r.a     = rnd ? $random(seed) : a;
        r.b     = rnd ? $random(seed) : b;
        r.pm    = pred[1];
        r.pt    = pred[0];
        r.btb   = btb;
        r.valid = valid;
        r.stall = stl;
        r.no_op = nop;
        r.exp   = predict(r.instr, r.pc, r.a, r.b, r.pm, r.pt, r.btb);
        rows.push_back(r);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table with columns instr, a, b, random, {made, taken}, btb,
    // valid, stall and no_op
    // ------------------------------------------------------------------------
    task automatic build_table();
        logic [31:0] xr;
        xr = r_type(7'h00, 3'd4, 5'd12);
        add_row(r_type(7'h00, 3'd0, 5'd3), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h20, 3'd0, 5'd4), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd1, 5'd5), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd2, 5'd6), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd3, 5'd7), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd4, 5'd8), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd5, 5'd9), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h20, 3'd5, 5'd10), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd6, 5'd11), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd7, 5'd12), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(i_type(12'hffb, 3'd0, 5'd13, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h800, 3'd2, 5'd14, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(i_type(12'hfff, 3'd4, 5'd15, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h407, 3'd5, 5'd16, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h003, 3'd1, 5'd17, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(u_type(20'habcde, 5'd7, 7'h37), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(u_type(20'h12345, 5'd8, 7'h17), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        // Each mispredicted branch or jump kills the row after it.
        add_row(b_type(13'h010, 3'd0), 32'd5, 32'd5, 1'b0, 2'b11, next_pc() + 32'h10,
                1'b1, 1'b0, 1'b0);
        add_row(b_type(13'h020, 3'd1), 32'd1, 32'd1, 1'b0, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(b_type(13'h1ff0, 3'd4), 32'hffff_ffff, 32'd1, 1'b0, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h055, 3'd0, 5'd18, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(b_type(13'h040, 3'd7), 32'd1, 32'd2, 1'b0, 2'b11, next_pc() + 32'h40,
                1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd0, 5'd19), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(j_type(21'h000040, 5'd1), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd0, 5'd20), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h010, 3'd0, 5'd2, 7'h67), 32'h0000_1001, 32'h0, 1'b0, 2'b11,
                32'h0000_1010, 1'b1, 1'b0, 1'b0);
        add_row(b_type(13'h018, 3'd5), 32'd5, 32'd3, 1'b0, 2'b11, next_pc() + 32'h20,
                1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h00, 3'd6, 5'd21), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(s_type(12'hff8, 3'd2), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(i_type(12'h00c, 3'd2, 5'd9, 7'h03), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        // Bubbles from no_op and from a gap in valid.
        add_row(r_type(7'h00, 3'd0, 5'd22), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b1);
        add_row(r_type(7'h00, 3'd0, 5'd23), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(i_type(12'h123, 3'd0, 5'd10, 7'h13), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0,
                1'b1, 1'b0, 1'b0);
        add_row(r_type(7'h20, 3'd0, 5'd11), 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(xr, 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b1, 1'b0);
        add_row(xr, 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b1, 1'b0);
        add_row(xr, 32'h0, 32'h0, 1'b1, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(32'h0, 32'h0, 32'h0, 1'b0, 2'b00, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(32'h0, 32'h0, 32'h0, 1'b0, 2'b00, 32'h0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h (step %0d)", name, got, exp,
                     step);
        end
    endtask

    task automatic compare_outputs();
        check("reg_write", 32'(reg_write), 32'(ew_model.reg_write));
        check("mem_write", 32'(mem_write), 32'(ew_model.mem_write));
        check("result_src", 32'(result_src), 32'(ew_model.result_src));
        check("rd", 32'(rd), 32'(ew_model.rd));
        if (ew_model.res_chk) check("result", result, ew_model.result);
        if (ew_model.mem_write) check("store_data", store_data, ew_model.store_data);
        check("redirect_valid", 32'(redirect_valid), 32'(de_model.redirect));
        if (de_model.redirect) check("redirect_pc", redirect_pc, de_model.redirect_pc);
    endtask

    task automatic drive_row(input row_t r);
        in_valid        = r.valid;
        stall           = r.stall;
        no_op           = r.no_op;
        instr           = r.instr;
        pc              = r.pc;
        r_out1          = r.a;
        r_out2          = r.b;
        prediction_made = r.pm;
        predicted_taken = r.pt;
        btb_target      = r.btb;
    endtask

    task automatic wait_idle(input int max_cycles, output bit idle);
        int n;
        n    = 0;
        idle = 1'b0;
        while (!idle && n < max_cycles) begin
            @(negedge clk);
            n++;
            idle = !reg_write && !mem_write && !redirect_valid;
        end
        if (!idle) $display("Timeout: pipeline did not go idle within %0d cycles", max_cycles);
    endtask

    initial begin
        rst      = 1'b1;
        errors   = 0;
        checks   = 0;
        step     = 0;
        de_model = '0;
        ew_model = '0;
        drive_row('0);
        in_valid = 1'b1;
        instr    = j_type(21'h000040, 5'd1); // Writes and redirects unless reset clears it.
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        compare_outputs();
        drive_row('0);
        rst = 1'b0;
        for (int k = 0; k < rows.size(); k++) begin
            @(negedge clk);
            step = k;
            compare_outputs();
            drive_row(rows[k]);
            if (!rows[k].stall) begin
                ew_model = de_model;
                if (de_model.redirect || rows[k].no_op || !rows[k].valid) de_model = '0;
                else de_model = rows[k].exp;
            end
        end
        drive_row('0);
        wait_idle(16, ok);
        if (!ok) errors++;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/de_bus_if.sv
rtl/decode_unit.sv
rtl/pipe_reg.sv
rtl/execute_unit.sv
rtl/decode_execute_core.sv
verification/tb_decode_execute_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_decode_execute_core
FILELIST   ?= sim.f
SIM_FLAGS  ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
